//--- bitpack.f
+incdir+.
bitpack_pkg.sv
bitpack_sync_fifo.sv
bitpack_bit_fifo.sv
bitpack_packer.sv
bitpack_top.sv
bitpack_assert.sv
bitpack_tb.sv

//--- bitpack_assert.sv
`timescale 1ns/10ps
`include "bitpack_defs.svh"

module bitpack_assert (
   input logic                clk_i,
   input logic                rst_i,
   input logic                in_read_i,
   input logic                in_empty_i,
   input logic                out_write_i,
   input logic                out_full_i,
   input bitpack_pkg::level_t fill_level_i
);

   localparam bitpack_pkg::level_t BUF_LEVEL = bitpack_pkg::level_t'(`BITPACK_BUF_W);

   // input queue is read only with a head word present
   in_read_not_empty: assert property (@(posedge clk_i) disable iff (rst_i)
      in_read_i |-> !in_empty_i)
      else $error("input FIFO read while empty");

   // registered write must never hit a full output queue
   out_write_not_full: assert property (@(posedge clk_i) disable iff (rst_i)
      out_write_i |-> !out_full_i)
      else $error("output FIFO written while full");

   // bit buffer holds at most one word
   fill_in_range: assert property (@(posedge clk_i) disable iff (rst_i)
      fill_level_i <= BUF_LEVEL)
      else $error("bit FIFO fill level above capacity");

   // strobes quiet right after a reset cycle
   strobes_low_after_reset: assert property (@(posedge clk_i)
      rst_i |=> (!in_read_i && !out_write_i))
      else $error("read or write strobe high after reset");

endmodule

bind bitpack_top bitpack_assert assert_i (
   .clk_i        (clk_i),
   .rst_i        (rst_i),
   .in_read_i    (in_read),
   .in_empty_i   (in_empty),
   .out_write_i  (out_write),
   .out_full_i   (out_full),
   .fill_level_i (packer.fill_level)
);

//--- bitpack_bit_fifo.sv
`timescale 1ns/10ps
`include "bitpack_defs.svh"

module bitpack_bit_fifo (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  push_i,
   input  bitpack_pkg::len_t      push_len_i,
   input  bitpack_pkg::unpacked_t push_data_i,
   input  logic                  pop_i,
   output bitpack_pkg::packed_t   pop_data_o,
   output bitpack_pkg::level_t    free_level_o,
   output bitpack_pkg::level_t    fill_level_o
);

   localparam int BUF_W    = `BITPACK_BUF_W;
   localparam int PACKED_W = `BITPACK_PACKED_W;

   // left aligned store, oldest bit at the msb
   logic [BUF_W-1:0]    buf_q;
   bitpack_pkg::level_t fill_q;

   logic [BUF_W-1:0]    push_mask;
   logic [BUF_W-1:0]    push_bits;
   bitpack_pkg::level_t push_shift;
   bitpack_pkg::level_t push_len_lvl;

   assign push_len_lvl = bitpack_pkg::level_t'(push_len_i);

   // keep only the low push_len_i bits of the field
   assign push_mask = ~({BUF_W{1'b1}} << push_len_i);
   assign push_bits = BUF_W'(push_data_i) & push_mask;

   // place the new bits just below the current fill
   // the packer never pushes more than the free level
   assign push_shift = bitpack_pkg::level_t'(BUF_W) - fill_q - push_len_lvl;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         buf_q  <= '0;
         fill_q <= '0;
      end else if (push_i) begin
         buf_q  <= buf_q | (push_bits << push_shift);
         fill_q <= fill_q + push_len_lvl;
      end else if (pop_i) begin
         // remaining bits move up to the msb, zeros fill in below
         buf_q  <= buf_q << PACKED_W;
         fill_q <= fill_q - bitpack_pkg::level_t'(PACKED_W);
      end
   end

   // popped word is the top of the store before the shift
   assign pop_data_o   = buf_q[BUF_W-1 -: PACKED_W];
   assign fill_level_o = fill_q;
   assign free_level_o = bitpack_pkg::level_t'(BUF_W) - fill_q;

endmodule

//--- bitpack_defs.svh
`ifndef BITPACK_DEFS_SVH
`define BITPACK_DEFS_SVH

// width of one field written by the producer
`define BITPACK_UNPACKED_W 12

// width of one word read by the consumer
`define BITPACK_PACKED_W 16

// field length from 1 to 12
`define BITPACK_LEN_W 5

// bit buffer capacity as the larger of the field and word widths
`define BITPACK_BUF_W 16

// bit buffer level from 0 to 16
`define BITPACK_LEVEL_W 5

// entries in each word queue
`define BITPACK_FIFO_DEPTH 8

`endif

//--- bitpack_packer.sv
`timescale 1ns/10ps
`include "bitpack_defs.svh"

module bitpack_packer (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  bitpack_pkg::len_t      len_i,
   input  logic                  wrap_i,
   input  logic                  rready_i,
   input  bitpack_pkg::unpacked_t rdata_i,
   input  logic                  wready_i,
   output logic                  read_o,
   output logic                  write_o,
   output bitpack_pkg::packed_t   wdata_o
);

   localparam bitpack_pkg::level_t WORD_LEVEL = bitpack_pkg::level_t'(`BITPACK_PACKED_W);

   bitpack_pkg::packer_state_t state_q;
   bitpack_pkg::packer_state_t state_nxt;
   bitpack_pkg::unpacked_t     data_q;
   // bits of the held field not yet in the bit buffer
   bitpack_pkg::len_t          rem_q;
   bitpack_pkg::len_t          rem_nxt;

   logic                       read;
   logic                       push;
   bitpack_pkg::len_t          push_len;
   bitpack_pkg::unpacked_t     push_data;
   logic                       pop;
   bitpack_pkg::packed_t       pop_data;
   bitpack_pkg::level_t        free_level;
   bitpack_pkg::level_t        fill_level;

   logic                       fits;
   bitpack_pkg::len_t          chunk_len;
   bitpack_pkg::unpacked_t     chunk_data;

   logic                       write_q;
   bitpack_pkg::packed_t       wdata_q;

   // a field larger than the free space is split across two words
   assign fits       = free_level >= bitpack_pkg::level_t'(rem_q);
   assign chunk_len  = fits ? rem_q : bitpack_pkg::len_t'(free_level);
   assign chunk_data = data_q >> (rem_q - chunk_len);

   always_comb begin
      read      = 1'b0;
      push      = 1'b0;
      push_len  = chunk_len;
      push_data = chunk_data;
      pop       = 1'b0;
      state_nxt = state_q;
      rem_nxt   = rem_q;

      if (state_q == bitpack_pkg::HELD && free_level != '0) begin
         push = 1'b1;
         if (!fits) begin
            rem_nxt = rem_q - chunk_len;
         end else if (rready_i) begin
            // next field replaces the one just pushed
            read    = 1'b1;
            rem_nxt = len_i;
         end else begin
            state_nxt = bitpack_pkg::IDLE;
         end
      end else if (wrap_i && fill_level != '0 && fill_level < WORD_LEVEL) begin
         // zero pad the partial word so it can leave
         push      = 1'b1;
         push_len  = bitpack_pkg::len_t'(free_level);
         push_data = '0;
      end else if (fill_level == WORD_LEVEL && wready_i) begin
         pop = 1'b1;
      end else if (state_q == bitpack_pkg::IDLE && rready_i) begin
         read      = 1'b1;
         rem_nxt   = len_i;
         state_nxt = bitpack_pkg::HELD;
      end
   end

   bitpack_bit_fifo bit_fifo (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .push_i       (push),
      .push_len_i   (push_len),
      .push_data_i  (push_data),
      .pop_i        (pop),
      .pop_data_o   (pop_data),
      .free_level_o (free_level),
      .fill_level_o (fill_level)
   );

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= bitpack_pkg::IDLE;
         rem_q   <= '0;
         write_q <= 1'b0;
      end else begin
         state_q <= state_nxt;
         rem_q   <= rem_nxt;
         write_q <= pop;
      end
   end

   always_ff @(posedge clk_i) begin
      if (read) begin
         data_q <= rdata_i;
      end
      if (pop) begin
         wdata_q <= pop_data;
      end
   end

   assign read_o  = read;
   assign write_o = write_q;
   assign wdata_o = wdata_q;

endmodule

//--- bitpack_pkg.sv
`include "bitpack_defs.svh"

package bitpack_pkg;

   // one field as written by the producer
   typedef logic [`BITPACK_UNPACKED_W-1:0] unpacked_t;

   // one packed output word
   typedef logic [`BITPACK_PACKED_W-1:0] packed_t;

   // number of valid bits in a field
   typedef logic [`BITPACK_LEN_W-1:0] len_t;

   // bit count in the bit buffer
   typedef logic [`BITPACK_LEVEL_W-1:0] level_t;

   // data register status of the packer
   typedef enum logic {
      IDLE,
      HELD
   } packer_state_t;

endpackage

//--- bitpack_sync_fifo.sv
`timescale 1ns/10ps
`include "bitpack_defs.svh"

module bitpack_sync_fifo #(
   parameter int WIDTH = `BITPACK_UNPACKED_W,
   parameter int DEPTH = `BITPACK_FIFO_DEPTH
) (
   input  logic             clk_i,
   input  logic             rst_i,
   input  logic             write_i,
   input  logic [WIDTH-1:0] data_i,
   input  logic             read_i,
   output logic [WIDTH-1:0] data_o,
   output logic             empty_o,
   output logic             full_o
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic [CNT_W-1:0] count_nxt;
   logic             empty_q;
   logic             full_q;
   logic             do_write;
   logic             do_read;

   // pointer advance with wrap at the last entry
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   // strobes outside the legal state are dropped
   assign do_write = write_i && !full_q;
   assign do_read  = read_i && !empty_q;

   always_comb begin
      count_nxt = count_q;
      case ({do_write, do_read})
         2'b10:   count_nxt = count_q + 1'b1;
         2'b01:   count_nxt = count_q - 1'b1;
         default: count_nxt = count_q;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (do_write) begin
         mem[wr_ptr_q] <= data_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
         empty_q  <= 1'b1;
         full_q   <= 1'b0;
      end else begin
         if (do_write) begin
            wr_ptr_q <= next_ptr(wr_ptr_q);
         end
         if (do_read) begin
            rd_ptr_q <= next_ptr(rd_ptr_q);
         end
         count_q <= count_nxt;
         // flags follow the next count so they are ready at the edge
         empty_q <= (count_nxt == '0);
         full_q  <= (count_nxt == CNT_W'(DEPTH));
      end
   end

   // head word is shown without waiting for a read
   assign data_o  = mem[rd_ptr_q];
   assign empty_o = empty_q;
   assign full_o  = full_q;

endmodule

//--- bitpack_tb.sv
`timescale 1ns/10ps
`include "bitpack_defs.svh"

module bitpack_tb;

   localparam int CLK_PERIOD       = 20;
   localparam int PACKED_W         = `BITPACK_PACKED_W;
   localparam int CYCLES_PER_FIELD = 200;

   logic                   clk_i;
   logic                   rst_i;
   bitpack_pkg::len_t      len_i;
   logic                   wrap_i;
   logic                   in_write_i;
   bitpack_pkg::unpacked_t in_data_i;
   logic                   out_read_i;
   logic                   in_full_o;
   bitpack_pkg::packed_t   out_data_o;
   logic                   out_empty_o;

   integer            seed = 32'h37236a4a;
   int                read_pct;
   int                fields_written;
   int                watch_cycles;
   bitpack_pkg::len_t cur_len;

   // model bits not yet forming a whole word, and words still to arrive
   bit                   ref_bits[$];
   bitpack_pkg::packed_t exp_words[$];

   bitpack_top UUT (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .len_i       (len_i),
      .wrap_i      (wrap_i),
      .in_write_i  (in_write_i),
      .in_data_i   (in_data_i),
      .out_read_i  (out_read_i),
      .in_full_o   (in_full_o),
      .out_data_o  (out_data_o),
      .out_empty_o (out_empty_o)
   );

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Verification failed");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic compare_word(input string name, input bitpack_pkg::packed_t got,
                               input bitpack_pkg::packed_t exp);
      if (got !== exp) begin
         report_failure($sformatf("mismatch at %0t: %s got %h expected %h",
                                  $time, name, got, exp));
      end
   endtask

   task automatic compare_level(input string name, input bitpack_pkg::level_t got,
                                input bitpack_pkg::level_t exp);
      if (got !== exp) begin
         report_failure($sformatf("mismatch at %0t: %s got %0d expected %0d",
                                  $time, name, got, exp));
      end
   endtask

   task automatic compare_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         report_failure($sformatf("mismatch at %0t: %s got %b expected %b",
                                  $time, name, got, exp));
      end
   endtask

   // oldest bit becomes the msb of the word
   function automatic bitpack_pkg::packed_t take_word();
      bitpack_pkg::packed_t w;
      int i;
      for (i = PACKED_W - 1; i >= 0; i--) begin
         w[i] = ref_bits.pop_front();
      end
      return w;
   endfunction

   function automatic void append_field_bits(input bitpack_pkg::unpacked_t data,
                                             input bitpack_pkg::len_t len);
      int i;
      for (i = int'(len) - 1; i >= 0; i--) begin
         ref_bits.push_back(data[i]);
      end
      while (ref_bits.size() >= PACKED_W) begin
         exp_words.push_back(take_word());
      end
   endfunction

   // wrap closes a partial word with zeros
   function automatic void pad_to_word();
      if (ref_bits.size() > 0) begin
         while (ref_bits.size() < PACKED_W) begin
            ref_bits.push_back(1'b0);
         end
         exp_words.push_back(take_word());
      end
   endfunction

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   // consumer read strobe at random with a set rate
   always @(posedge clk_i) begin
      if (rst_i) begin
         out_read_i <= 1'b0;
      end else begin
         out_read_i <= ({$random(seed)} % 100) < read_pct;
      end
   end

   // word leaves the output queue at the next edge
   always @(negedge clk_i) begin
      if (!rst_i && out_read_i && !out_empty_o) begin
         if (exp_words.size() == 0) begin
            report_failure("a word arrived on out_data_o while the model expected none");
         end else begin
            compare_word("out_data_o", out_data_o, exp_words.pop_front());
         end
      end
   end

   initial begin
      watch_cycles = 0;
      forever begin
         @(posedge clk_i);
         watch_cycles++;
         if (watch_cycles > CYCLES_PER_FIELD * (fields_written + 10)) begin
            report_failure($sformatf("timeout after %0d cycles with %0d fields written",
                                     watch_cycles, fields_written));
         end
      end
   end

   // write goes in only when the input queue has room
   task automatic write_field(input bitpack_pkg::unpacked_t data);
      @(negedge clk_i);
      while (in_full_o) begin
         @(negedge clk_i);
      end
      @(posedge clk_i);
      in_write_i <= 1'b1;
      in_data_i  <= data;
      append_field_bits(data, cur_len);
      fields_written++;
      @(posedge clk_i);
      in_write_i <= 1'b0;
   endtask

   task automatic drain_with_wrap();
      // all fields must be in the bit buffer before padding
      @(negedge clk_i);
      while (!(UUT.in_fifo.empty_o && UUT.packer.state_q == bitpack_pkg::IDLE)) begin
         @(negedge clk_i);
      end
      @(posedge clk_i);
      wrap_i <= 1'b1;
      pad_to_word();
      // quiet once the bit buffer is empty and no word is in flight or queued
      @(negedge clk_i);
      while (!(UUT.packer.fill_level == '0 && !UUT.out_write && out_empty_o)) begin
         @(negedge clk_i);
      end
      @(posedge clk_i);
      wrap_i <= 1'b0;
      @(negedge clk_i);
      compare_level("pending_words", bitpack_pkg::level_t'(exp_words.size()), '0);
   endtask

   task automatic start_phase(input int len, input int pct);
      @(posedge clk_i);
      len_i    <= bitpack_pkg::len_t'(len);
      cur_len  = bitpack_pkg::len_t'(len);
      read_pct <= pct;
   endtask

   task automatic run_phase(input int len, input int nfields, input int max_gap,
                            input int pct);
      int i;
      int gap;
      start_phase(len, pct);
      for (i = 0; i < nfields; i++) begin
         gap = {$random(seed)} % (max_gap + 1);
         repeat (gap) @(posedge clk_i);
         write_field(bitpack_pkg::unpacked_t'($random(seed)));
      end
      drain_with_wrap();
   endtask

   // consumer stalls until the input queue reports full
   task automatic stall_phase(input int len);
      int  i;
      logic full_seen;
      start_phase(len, 0);
      full_seen = 1'b0;
      while (!full_seen) begin
         write_field(bitpack_pkg::unpacked_t'($random(seed)));
         @(negedge clk_i);
         full_seen = in_full_o;
      end
      repeat (10 + {$random(seed)} % 30) @(posedge clk_i);
      read_pct <= 35;
      for (i = 0; i < 10; i++) begin
         write_field(bitpack_pkg::unpacked_t'($random(seed)));
      end
      drain_with_wrap();
   endtask

   initial begin
      int p;
      rst_i          = 1'b1;
      len_i          = bitpack_pkg::len_t'(8);
      cur_len        = bitpack_pkg::len_t'(8);
      wrap_i         = 1'b0;
      in_write_i     = 1'b0;
      in_data_i      = '0;
      out_read_i     = 1'b0;
      read_pct       = 0;
      fields_written = 0;
      repeat (2) @(posedge clk_i);
      rst_i <= 1'b0;

      // idle pipeline after reset
      @(negedge clk_i);
      compare_flag("out_empty_o", out_empty_o, 1'b1);
      compare_flag("in_full_o", in_full_o, 1'b0);
      read_pct = 100;
      repeat (30) @(posedge clk_i);
      @(negedge clk_i);
      compare_flag("out_empty_o", out_empty_o, 1'b1);

      run_phase(8, 16, 0, 100);
      run_phase(5, 40, 2, 70);
      run_phase(1, 40, 1, 80);
      run_phase(12, 20, 1, 80);
      stall_phase(7);

      // random length and traffic per phase
      for (p = 0; p < 6; p++) begin
         run_phase(1 + {$random(seed)} % 12, 12, {$random(seed)} % 4,
                   20 + {$random(seed)} % 81);
      end

      $display("%0d fields written", fields_written);
      $display("Verification passed");
      $finish;
   end

endmodule

//--- bitpack_top.sv
`timescale 1ns/10ps
`include "bitpack_defs.svh"

module bitpack_top (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  bitpack_pkg::len_t      len_i,
   input  logic                  wrap_i,
   input  logic                  in_write_i,
   input  bitpack_pkg::unpacked_t in_data_i,
   input  logic                  out_read_i,
   output logic                  in_full_o,
   output bitpack_pkg::packed_t   out_data_o,
   output logic                  out_empty_o
);

   // input queue to packer
   bitpack_pkg::unpacked_t in_rdata;
   logic                   in_empty;
   logic                   in_read;

   // packer to output queue
   bitpack_pkg::packed_t   out_wdata;
   logic                   out_write;
   logic                   out_full;

   bitpack_sync_fifo #(
      .WIDTH (`BITPACK_UNPACKED_W),
      .DEPTH (`BITPACK_FIFO_DEPTH)
   ) in_fifo (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .write_i (in_write_i),
      .data_i  (in_data_i),
      .read_i  (in_read),
      .data_o  (in_rdata),
      .empty_o (in_empty),
      .full_o  (in_full_o)
   );

   bitpack_packer packer (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .len_i    (len_i),
      .wrap_i   (wrap_i),
      .rready_i (!in_empty),
      .rdata_i  (in_rdata),
      .wready_i (!out_full),
      .read_o   (in_read),
      .write_o  (out_write),
      .wdata_o  (out_wdata)
   );

   bitpack_sync_fifo #(
      .WIDTH (`BITPACK_PACKED_W),
      .DEPTH (`BITPACK_FIFO_DEPTH)
   ) out_fifo (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .write_i (out_write),
      .data_i  (out_wdata),
      .read_i  (out_read_i),
      .data_o  (out_data_o),
      .empty_o (out_empty_o),
      .full_o  (out_full)
   );

endmodule
